/* src/uart_load_defs.svh */
`ifndef UART_LOAD_DEFS_SVH
`define UART_LOAD_DEFS_SVH

// Clock cycles per serial bit.
`define CLKS_PER_BIT 8

// Bytes per assembled word, and the resulting word width.
`define WORD_BYTES 4
`define WORD_BITS (`WORD_BYTES * 8)

// Word address width of the load memory.
`define MEM_ADDR_BITS 4

`endif

/* src/uart_load_pkg.sv */
`default_nettype none

`include "uart_load_defs.svh"

package uart_load_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [`WORD_BITS-1:0] word_t;

    // The receiver waits in idle for a falling edge on the line.
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_load_defs.svh"

module uart_rx
    import uart_load_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  io_rx,
    output logic  io_data_valid,
    output byte_t io_data_packet,
    output logic  frame_error
);

    localparam int cnt_bits = $clog2(`CLKS_PER_BIT) + 1;
    localparam logic [cnt_bits-1:0] half_bit = cnt_bits'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [cnt_bits-1:0] full_bit = cnt_bits'(`CLKS_PER_BIT - 1);

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    rx_state_t state;
    logic [cnt_bits-1:0] bit_cnt;
    logic [2:0] bit_idx;
    byte_t shift_reg;

    // The idle line is high, so the synchronizer resets to one.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else begin
            rx_meta <= io_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= rx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            io_data_valid <= 1'b0;
            frame_error <= 1'b0;
        end
        else begin
            io_data_valid <= 1'b0;
            frame_error <= 1'b0;

            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // A start bit that is gone at its middle was a glitch.
                    if (bit_cnt == half_bit) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_sync ? rx_idle : rx_data;
                    end
                    else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_cnt == full_bit) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                    else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_cnt == full_bit) begin
                        bit_cnt <= '0;
                        state <= rx_idle;
                        if (rx_sync) begin
                            io_data_valid <= 1'b1;
                        end
                        else begin
                            frame_error <= 1'b1;
                        end
                    end
                    else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Data bits arrive least significant first.
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_cnt == full_bit) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign io_data_packet = shift_reg;

endmodule

`default_nettype wire

/* src/uart_word_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_load_defs.svh"

module uart_word_assembler
    import uart_load_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        io_rx,
    output logic        data_valid,
    output word_t       data_out,
    output logic [31:0] byte_address,
    output logic        frame_error
);

    localparam int count_bits = $clog2(`WORD_BYTES);
    localparam logic [count_bits-1:0] last_byte = count_bits'(`WORD_BYTES - 1);

    logic io_data_valid;
    logic io_data_valid_delayed;
    byte_t io_data_packet;

    logic [31:0] byte_address_next;
    logic en_address_increment;
    logic en_address_increment_next;

    logic [count_bits-1:0] byte_counter;
    logic [count_bits-1:0] byte_counter_next;
    logic data_valid_next;
    word_t data_out_next;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_address <= '0;
            byte_counter <= '0;
            data_valid <= 1'b0;
            en_address_increment <= 1'b0;
            io_data_valid_delayed <= 1'b0;
            data_out <= '0;
        end
        else begin
            byte_address <= byte_address_next;
            byte_counter <= byte_counter_next;
            data_valid <= data_valid_next;
            en_address_increment <= en_address_increment_next;
            io_data_valid_delayed <= io_data_valid;
            data_out <= data_out_next;
        end
    end

    // The first byte only arms the increment, so byte indices start at zero.
    always_comb begin
        byte_address_next = byte_address;
        byte_counter_next = byte_counter;
        en_address_increment_next = en_address_increment;
        data_valid_next = io_data_valid && (byte_counter == last_byte);
        data_out_next = data_out;

        if (io_data_valid_delayed) begin
            byte_counter_next = byte_counter + 1'b1;
            en_address_increment_next = 1'b1;
            if (en_address_increment) begin
                byte_address_next = byte_address + 32'd1;
            end
        end

        // New bytes enter at the bottom, so the first one ends up on top.
        if (io_data_valid) begin
            data_out_next = {data_out[$bits(word_t)-$bits(byte_t)-1:0], io_data_packet};
        end
    end

    uart_rx uart_rx_inst (
        .clk(clk),
        .reset_n(reset_n),
        .io_rx(io_rx),
        .io_data_valid(io_data_valid),
        .io_data_packet(io_data_packet),
        .frame_error(frame_error)
    );

endmodule

`default_nettype wire

/* src/load_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_load_defs.svh"

module load_memory
    import uart_load_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      wr_en,
    input  logic [31:0]               byte_address,
    input  word_t                     wr_data,
    input  logic [`MEM_ADDR_BITS-1:0] rd_addr,
    output word_t                     rd_data
);

    localparam int depth = 2 ** `MEM_ADDR_BITS;

    word_t mem [depth];

    logic [31:0] word_index;
    logic [`MEM_ADDR_BITS-1:0] wr_addr;

    // Any byte of a word maps to that word's slot, wrapping at the depth.
    assign word_index = byte_address / `WORD_BYTES;
    assign wr_addr = word_index[`MEM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end
        else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* src/uart_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_load_defs.svh"

module uart_loader_top
    import uart_load_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      rx,
    output logic                      word_valid,
    output word_t                     word_data,
    output logic [31:0]               word_byte_address,
    output logic                      frame_error,
    input  logic [`MEM_ADDR_BITS-1:0] rd_addr,
    output word_t                     rd_data
);

    uart_word_assembler uart_word_assembler_inst (
        .clk(clk),
        .reset_n(reset_n),
        .io_rx(rx),
        .data_valid(word_valid),
        .data_out(word_data),
        .byte_address(word_byte_address),
        .frame_error(frame_error)
    );

    // Each finished word is written straight into the memory.
    load_memory load_memory_inst (
        .clk(clk),
        .reset_n(reset_n),
        .wr_en(word_valid),
        .byte_address(word_byte_address),
        .wr_data(word_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

/* tb/uart_loader_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_load_defs.svh"

module uart_loader_tb
    import uart_load_pkg::*;
();

    localparam int num_words = 20;
    localparam int num_bad_frames = 2;
    localparam int total_frames = num_words * `WORD_BYTES + num_bad_frames;
    localparam int timeout_cycles = total_frames * 10 * `CLKS_PER_BIT + 200;
    localparam int word_idx_bits = 5;
    localparam int mem_depth = 2 ** `MEM_ADDR_BITS;

    logic clk = 1'b0;
    logic reset_n;
    logic rx;
    logic word_valid;
    word_t word_data;
    logic [31:0] word_byte_address;
    logic frame_error;
    logic [`MEM_ADDR_BITS-1:0] rd_addr;
    word_t rd_data;

    integer seed = 32'hcaec2f3b;

    // Reference model of the host stream and of the memory contents.
    byte_t good_bytes[$];
    int good_count = 0;
    int bad_frames_sent = 0;
    word_t expected_words [2 ** word_idx_bits];
    word_t mem_model [mem_depth];
    logic frame_started = 1'b0;

    int word_count;
    int frame_error_count;
    int cycle_count = 0;

    logic read_active;
    word_t rd_expected;
    logic rd_check;
    word_t rd_check_value;

    always #50 clk = ~clk;

    uart_loader_top uart_loader_top_inst (
        .clk(clk),
        .reset_n(reset_n),
        .rx(rx),
        .word_valid(word_valid),
        .word_data(word_data),
        .word_byte_address(word_byte_address),
        .frame_error(frame_error),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic failure(input string reason);
        $display("** Error at %0t: %s", $time, reason);
        abort_run();
    endtask

    task automatic drive_frame(input byte_t value, input logic stop_level);
        frame_started <= 1'b1;
        rx <= 1'b0;
        repeat (`CLKS_PER_BIT) @(posedge clk);
        for (int b = 0; b < 8; b++) begin
            rx <= value[b];
            repeat (`CLKS_PER_BIT) @(posedge clk);
        end
        rx <= stop_level;
        repeat (`CLKS_PER_BIT) @(posedge clk);
    endtask

    // The first byte of each group lands in the most significant position.
    task automatic send_good_byte(input byte_t value);
        int base;
        word_t w;
        good_bytes.push_back(value);
        good_count = good_count + 1;
        if (good_count % `WORD_BYTES == 0) begin
            base = good_count - `WORD_BYTES;
            w = '0;
            for (int k = 0; k < `WORD_BYTES; k++) begin
                w = (w << 8) | word_t'(good_bytes[base + k]);
            end
            expected_words[word_idx_bits'(base / `WORD_BYTES)] = w;
            mem_model[`MEM_ADDR_BITS'(base / `WORD_BYTES)] = w;
        end
        drive_frame(value, 1'b1);
    endtask

    task automatic send_bad_frame(input byte_t value);
        bad_frames_sent = bad_frames_sent + 1;
        drive_frame(value, 1'b0);
        // The line has to go high again before a new start edge exists.
        rx <= 1'b1;
        repeat (2 * `CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic read_words(input int count);
        for (int a = 0; a < count; a++) begin
            rd_addr <= `MEM_ADDR_BITS'(a);
            rd_expected <= mem_model[`MEM_ADDR_BITS'(a)];
            read_active <= 1'b1;
            @(posedge clk);
        end
        read_active <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            word_count <= 0;
            frame_error_count <= 0;
            rd_check <= 1'b0;
            rd_check_value <= '0;
        end
        else begin
            if (word_valid) begin
                word_count <= word_count + 1;
            end
            if (frame_error) begin
                frame_error_count <= frame_error_count + 1;
            end
            rd_check <= read_active;
            rd_check_value <= rd_expected;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
            abort_run();
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        !frame_started |-> !word_valid && !frame_error)
        else failure("word_valid or frame_error pulsed before any frame was sent");
    assert property (@(posedge clk) disable iff (!reset_n)
        !frame_started |-> word_data == '0)
        else mismatch("word_data", 32'd0, $sampled(word_data));
    assert property (@(posedge clk) disable iff (!reset_n)
        !frame_started |-> word_byte_address == '0)
        else mismatch("word_byte_address", 32'd0, $sampled(word_byte_address));
    assert property (@(posedge clk) disable iff (!reset_n)
        !frame_started |->
            uart_loader_top_inst.uart_word_assembler_inst.uart_rx_inst.state == rx_idle)
        else failure("the receiver left idle with no frame on the line");

    assert property (@(posedge clk) disable iff (!reset_n)
        word_valid |-> word_count < good_count / `WORD_BYTES)
        else failure("word_valid pulsed without a complete group of good bytes");
    assert property (@(posedge clk) disable iff (!reset_n)
        word_valid |-> word_data == expected_words[word_idx_bits'(word_count)])
        else mismatch("word_data", expected_words[word_idx_bits'($sampled(word_count))],
                      $sampled(word_data));
    assert property (@(posedge clk) disable iff (!reset_n)
        word_valid |-> word_byte_address / `WORD_BYTES == word_count)
        else mismatch("word_byte_address / WORD_BYTES", $sampled(word_count),
                      $sampled(word_byte_address) / `WORD_BYTES);
    // One cycle after the pulse the index names the last byte of the word.
    assert property (@(posedge clk) disable iff (!reset_n)
        word_valid |=> word_byte_address == word_count * `WORD_BYTES - 1)
        else mismatch("word_byte_address", $sampled(word_count) * `WORD_BYTES - 1,
                      $sampled(word_byte_address));

    assert property (@(posedge clk) disable iff (!reset_n)
        frame_error |-> frame_error_count < bad_frames_sent)
        else failure("frame_error pulsed with no bad frame outstanding");
    assert property (@(posedge clk) disable iff (!reset_n)
        rd_check |-> rd_data == rd_check_value)
        else mismatch("rd_data", $sampled(rd_check_value), $sampled(rd_data));

    initial begin
        reset_n <= 1'b0;
        rx <= 1'b1;
        rd_addr <= '0;
        read_active <= 1'b0;
        rd_expected <= '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        // A bad frame sits after the third good byte of word 2.
        for (int i = 0; i < 8 * `WORD_BYTES; i++) begin
            if (i == 11) begin
                send_bad_frame(byte_t'($random(seed)));
            end
            send_good_byte(byte_t'($random(seed)));
        end
        wait (word_count == 8);
        @(posedge clk);
        read_words(8);

        // Words 16 and up wrap around and overwrite slots 0 to 3.
        for (int i = 8 * `WORD_BYTES; i < num_words * `WORD_BYTES; i++) begin
            if (i == 71) begin
                send_bad_frame(byte_t'($random(seed)));
            end
            send_good_byte(byte_t'($random(seed)));
        end
        wait (word_count == num_words);
        @(posedge clk);
        read_words(mem_depth);

        assert (frame_error_count == num_bad_frames)
            else mismatch("frame_error count", num_bad_frames, frame_error_count);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/uart_load_pkg.sv
src/uart_rx.sv
src/uart_word_assembler.sv
src/load_memory.sv
src/uart_loader_top.sv
tb/uart_loader_tb.sv

/* Makefile */
VERILATOR  = verilator
FILE_LIST  = src.f
TOP        = uart_loader_tb
RTL_TOP    = uart_loader_top
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "All tests passed" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
